// ==== sources.f ====
+incdir+.
pcs_pkg.sv
pcs_enc.sv
pcs_scrambler.sv
am_gen.sv
gearbox_tx.sv
pcs_tx.sv
tb_pcs_tx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_pcs_tx -f sources.f -o tb_pcs_tx \
	&& ./obj_dir/tb_pcs_tx > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "RESULT: PASS" sim.log && exit 0 || { echo "testbench reported failure"; exit 1; }

// ==== tb_pcs_model.svh ====
// reference model for block encoding, descrambling and markers in the transmit PCS testbench
`ifndef TB_PCS_MODEL_SVH
`define TB_PCS_MODEL_SVH

// expected block before scrambling with the payload above the 2-bit header
function automatic logic [BLOCK_W-1:0] encode_block(
	input logic              ctrl,
	input logic              idle,
	input logic              start,
	input logic              term,
	input logic              err,
	input logic [DATA_W-1:0] data,
	input logic [KEEP_W-1:0] keep
);
	enc_payload_u p;
	logic [7:0]   term_type [KEEP_W]; // indexed by bytes before terminate
	int           n_bytes;
	int           n_kinds;
	term_type = '{BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
		BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7};
	n_bytes = 0;
	for (int i = 0; i < KEEP_W; i++) begin
		n_bytes += int'(keep[i]);
	end
	n_kinds = int'(idle) + int'(start) + int'(term); // one kind per control block
	p.raw   = '0;
	if (!ctrl) begin
		return {data, SYNC_DATA}; // data word as is
	end
	if (err || n_kinds != 1 || (term && n_bytes == KEEP_W)) begin
		p.ctrl.btype   = BT_ERR;
		p.ctrl.payload = {8{CTRL_ERR}};
	end else if (idle) begin
		p.ctrl.btype   = BT_IDLE; // payload stays all idle chars
	end else if (start) begin
		p.ctrl.btype   = BT_START;
		p.ctrl.payload = data[DATA_W-1:8]; // byte 0 gives way to the type
	end else begin
		p.ctrl.btype = term_type[n_bytes];
		for (int b = 0; b < KEEP_W - 1; b++) begin
			p.ctrl.payload[8*b +: 8] = (b < n_bytes) ? data[8*b +: 8] : 8'h00;
		end
	end
	return {p.raw, SYNC_CTRL};
endfunction

// one block through the self-synchronizing x^58 + x^39 + 1 descrambler
// result is {next state, clear payload}
function automatic logic [57+DATA_W:0] descramble_step(
	input logic [DATA_W-1:0] din,   // payload as received with bit 0 first
	input logic [57:0]       state  // last received bits with the newest at bit 0
);
	logic [DATA_W-1:0] dout;
	logic [57:0]       st;
	st = state;
	for (int i = 0; i < DATA_W; i++) begin
		dout[i] = din[i] ^ st[38] ^ st[57];
		st      = {st[56:0], din[i]}; // shift in the received bit and not the clear one
	end
	return {st, dout};
endfunction

// marker payload of one lane built byte by byte
// bytes 0..2 hold M0..M2 and bytes 4..6 hold M4..M6
function automatic logic [DATA_W-1:0] marker_payload(input int lane);
	logic [7:0]        mb [3];
	logic [DATA_W-1:0] p;
	for (int i = 0; i < 3; i++) begin
		mb[i] = AM_LANE[lane][8*i +: 8];
	end
	p = '0; // BIP3 and BIP7 bytes stay zero
	for (int i = 0; i < 3; i++) begin
		p[8*i +: 8]     = mb[i];
		p[8*(i+4) +: 8] = ~mb[i]; // inverted copy
	end
	return p;
endfunction

`endif

// ==== tb_pcs_tx.sv ====
// testbench for the 40GBASE-R transmit PCS that checks MAC words against the decoded lanes
module tb_pcs_tx import pcs_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int AM_PERIOD = 20;
	localparam int N_TESTS   = 5;

	logic                     clk;
	logic                     rst_i;
	logic [LANE_N-1:0]        ctrl_v_i;
	logic [LANE_N-1:0]        idle_v_i;
	logic [LANE_N-1:0]        start_v_i;
	logic [LANE_N-1:0]        term_v_i;
	logic [LANE_N-1:0]        err_v_i;
	logic [LANE_N*DATA_W-1:0] data_i;
	logic [LANE_N*KEEP_W-1:0] keep_i;
	logic                     ready_o;
	logic                     marker_v_o;
	logic [LANE_N*DATA_W-1:0] serdes_data_o;

	int seed = 37;
	int checks = 0;
	int errors [N_TESTS];
	int tests_run = 0;
	int tests_passed = 0;
	int cur_test = 0;                        // test that block mismatches count against
	logic [LANE_N*BLOCK_W-1:0] exp_q [$];    // accepted words with one block per lane
	int pushed = 0;
	int popped = 0;
	int dec_cnt [LANE_N];                    // data blocks decoded per lane
	bit taken = 1'b1;                        // last word went in so a new one may follow
	bit taken_prev = 1'b0;                   // whether the word before that went in
	int phase = 0;                           // position in the 33 cycle gearbox pattern
	int data_acc = 0;                        // words taken since the last marker slot
	bit in_frame [LANE_N];
	bit mon_run;
	logic [191:0] rx_buf [LANE_N];           // received bits with the oldest at bit 0
	int rx_fill = 0;
	logic [BLOCK_W-1:0] rx_blk [LANE_N];
	logic [57:0] ds_state [LANE_N];
	int lock_cnt = 0;                        // blocks dropped while descramblers lock
	int since_am = 0;
	int markers_seen = 0;

	`include "tb_pcs_model.svh"

	pcs_tx #(
		.AM_PERIOD(AM_PERIOD)
	) pcs_tx_inst (
		.clk          (clk),
		.rst_i        (rst_i),
		.ctrl_v_i     (ctrl_v_i),
		.idle_v_i     (idle_v_i),
		.start_v_i    (start_v_i),
		.term_v_i     (term_v_i),
		.err_v_i      (err_v_i),
		.data_i       (data_i),
		.keep_i       (keep_i),
		.ready_o      (ready_o),
		.marker_v_o   (marker_v_o),
		.serdes_data_o(serdes_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic expect_true(input bit ok, input int t, input string msg);
		checks++;
		assert (ok) else begin
			$display("CHECK FAILED at %0t ns: %s", $time, msg);
			errors[t]++;
		end
	endtask

	// new MAC word for one lane with a small frame state per lane
	task automatic pick_word(input int l, input bit quiet);
		int r;
		int n;
		r = quiet ? 9 : int'($unsigned($random(seed)) % 10);
		ctrl_v_i[l]  = 1'b1;
		idle_v_i[l]  = 1'b0;
		start_v_i[l] = 1'b0;
		term_v_i[l]  = 1'b0;
		err_v_i[l]   = 1'b0;
		data_i[l*DATA_W +: DATA_W] = {$random(seed), $random(seed)};
		keep_i[l*KEEP_W +: KEEP_W] = '0;
		if (quiet) begin
			idle_v_i[l] = 1'b1;
		end else if (r == 0) begin
			err_v_i[l] = 1'b1; // error wins over the random strobes
			{idle_v_i[l], start_v_i[l], term_v_i[l]} = 3'($unsigned($random(seed)));
			in_frame[l] = 1'b0;
		end else if (r == 1) begin
			idle_v_i[l] = 1'b1; // two kinds at once
			term_v_i[l] = 1'b1;
		end else if (in_frame[l]) begin
			if (r < 4) begin
				n = int'($unsigned($random(seed)) % 8);
				term_v_i[l] = 1'b1;
				keep_i[l*KEEP_W +: KEEP_W] = KEEP_W'((9'd1 << n) - 9'd1);
				in_frame[l] = 1'b0;
			end else begin
				ctrl_v_i[l] = 1'b0; // frame body
			end
		end else if (r < 5) begin
			start_v_i[l] = 1'b1;
			in_frame[l]  = 1'b1;
		end else begin
			idle_v_i[l] = 1'b1;
		end
	endtask

	// one MAC cycle with ready_o sampled before new inputs go out on the falling edge
	task automatic mac_cycle(input bit quiet);
		bit                        exp_ready;
		bit                        exp_marker;
		logic [LANE_N*BLOCK_W-1:0] exp_word;
		@(negedge clk);
		rst_i = 1'b0;
		if (pushed == 0) begin
			expect_true(ready_o === 1'b1 && marker_v_o === 1'b0, 0,
				$sformatf("after reset ready_o %b marker_v_o %b", ready_o, marker_v_o));
		end
		exp_marker = (data_acc == AM_PERIOD); // marker slot after a full period
		exp_ready  = (phase != 32) && !exp_marker; // 32 accepts then one skip
		expect_true(ready_o === exp_ready, 2,
			$sformatf("ready_o %b, expected %b at pattern step %0d", ready_o, exp_ready, phase));
		expect_true(marker_v_o === exp_marker, 3,
			$sformatf("marker_v_o %b after %0d data words", marker_v_o, data_acc));
		if (taken) begin
			for (int l = 0; l < LANE_N; l++) begin
				pick_word(l, quiet);
			end
		end
		if (ready_o === 1'b1) begin
			for (int l = 0; l < LANE_N; l++) begin
				exp_word[l*BLOCK_W +: BLOCK_W] = encode_block(ctrl_v_i[l], idle_v_i[l],
					start_v_i[l], term_v_i[l], err_v_i[l], data_i[l*DATA_W +: DATA_W],
					keep_i[l*KEEP_W +: KEEP_W]);
			end
			exp_q.push_back(exp_word);
			pushed++;
			data_acc++;
		end
		if (exp_marker && phase != 32) begin
			data_acc = 0; // marker goes out at this edge
		end
		taken_prev = taken;
		taken      = (ready_o === 1'b1); // else hold the word
		phase = (phase == 32) ? 0 : phase + 1;
	endtask

	// idle words until every word accepted so far has been compared
	task automatic drain(output bit ok);
		int target;
		int guard;
		target = pushed;
		guard  = 0;
		while (popped < target && guard < 200) begin
			mac_cycle(1'b1);
			guard++;
		end
		ok = (popped >= target);
		if (!ok) begin
			$display("timeout: %0d accepted MAC words never came out on the SerDes lanes",
				target - popped);
		end
	endtask

	task automatic report(input int t, input string name);
		tests_run++;
		if (errors[t] == 0) begin
			tests_passed++;
		end
		$display("test %0d %s: %s, %0d errors", t + 1, name,
			(errors[t] == 0) ? "pass" : "fail", errors[t]);
	endtask

	// one 66-bit block per lane as all lanes move in step
	task automatic check_block();
		logic [57+DATA_W:0]        ds;
		logic [LANE_N*BLOCK_W-1:0] exp_word;
		logic [BLOCK_W-1:0]        got;
		bit                        check_it;
		bit                        locked;
		exp_word = '0;
		check_it = 1'b0;
		locked   = 1'b0;
		if (rx_blk[0] == {marker_payload(0), SYNC_CTRL}) begin
			for (int l = 0; l < LANE_N; l++) begin
				expect_true(rx_blk[l] == {marker_payload(l), SYNC_CTRL}, 3,
					$sformatf("lane %0d marker block %h", l, rx_blk[l]));
			end
			expect_true(since_am == AM_PERIOD, 3,
				$sformatf("marker after %0d data blocks", since_am));
			since_am = 0;
			markers_seen++;
		end else begin
			since_am++; // reset idle block counts too
			if (lock_cnt < 2) begin
				if (lock_cnt == 1) begin
					exp_word = exp_q.pop_front(); // first word is scrambled from the seed
					popped++;
				end
				lock_cnt++;
			end else begin
				locked = 1'b1;
				expect_true(exp_q.size() > 0, 4, "data block with no accepted MAC word left");
				if (exp_q.size() > 0) begin
					exp_word = exp_q.pop_front();
					popped++;
					check_it = 1'b1;
				end
			end
			for (int l = 0; l < LANE_N; l++) begin
				ds          = descramble_step(rx_blk[l][BLOCK_W-1:HEAD_W], ds_state[l]);
				ds_state[l] = ds[57+DATA_W:DATA_W];
				got         = {ds[DATA_W-1:0], rx_blk[l][HEAD_W-1:0]};
				if (check_it) begin
					expect_true(got == exp_word[l*BLOCK_W +: BLOCK_W], cur_test,
						$sformatf("lane %0d block %h, expected %h", l, got,
						exp_word[l*BLOCK_W +: BLOCK_W]));
				end
				if (locked) begin
					dec_cnt[l]++; // counted even with no word left to compare
				end
			end
		end
	endtask

	always @(posedge clk) begin
		mon_run <= ~rst_i; // first word after reset is at the next falling edge
	end

	// reassemble each lane with bit 0 of every word first
	always @(negedge clk) begin
		if (mon_run) begin
			for (int l = 0; l < LANE_N; l++) begin
				rx_buf[l] = rx_buf[l] | ({128'd0, serdes_data_o[l*DATA_W +: DATA_W]} << rx_fill);
			end
			rx_fill = rx_fill + DATA_W;
			while (rx_fill >= BLOCK_W) begin
				for (int l = 0; l < LANE_N; l++) begin
					rx_blk[l] = rx_buf[l][BLOCK_W-1:0];
					rx_buf[l] = rx_buf[l] >> BLOCK_W;
				end
				rx_fill = rx_fill - BLOCK_W;
				check_block();
			end
		end
	end

	initial begin
		bit ok;
		int total;
		int in_flight;
		rst_i     = 1'b1;
		ctrl_v_i  = '1; // idle on every lane
		idle_v_i  = '1;
		start_v_i = '0;
		term_v_i  = '0;
		err_v_i   = '0;
		data_i    = '0;
		keep_i    = '0;
		for (int l = 0; l < LANE_N; l++) begin
			rx_buf[l]   = '0;
			ds_state[l] = '0;
			dec_cnt[l]  = 0;
			in_frame[l] = 1'b0;
		end
		for (int t = 0; t < N_TESTS; t++) begin
			errors[t] = 0;
		end
		repeat (16) @(posedge clk);
		repeat (40) mac_cycle(1'b1);
		drain(ok);
		if (ok) begin
			report(0, "reset state and idle stream");
			cur_test = 1;
			repeat (600) mac_cycle(1'b0);
			drain(ok);
		end
		if (ok) begin
			report(1, "random frames against reference blocks");
			report(2, "ready_o low once per 33 cycles");
			expect_true(markers_seen > 0, 3, "no alignment marker reached the SerDes lanes");
			report(3, "alignment marker slots and patterns");
			@(posedge clk); // monitor done with the last falling edge
			// words taken in the last two cycles and the one before them are still in flight
			in_flight = 1 + int'(taken_prev) + int'(taken);
			for (int l = 0; l < LANE_N; l++) begin
				// one accepted word was dropped during descrambler lock
				expect_true(dec_cnt[l] == pushed - in_flight - 1, 4,
					$sformatf("lane %0d decoded %0d blocks for %0d accepted words", l,
					dec_cnt[l], pushed - in_flight - 1));
			end
			report(4, "no lost or repeated blocks under stall");
		end
		total = 0;
		for (int t = 0; t < N_TESTS; t++) begin
			total += errors[t];
		end
		$display("summary: %0d of %0d tests passed, %0d checks, %0d errors",
			tests_passed, tests_run, checks, total);
		if (ok && total == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== pcs_tx.sv ====
// 40GBASE-R transmit PCS top, four block paths, marker insertion and four gearboxes
module pcs_tx import pcs_pkg::*; #(
	parameter int AM_PERIOD = 64 // data cycles between alignment markers
)(
	input  logic                     clk,
	input  logic                     rst_i,
	// MAC side, one strobe per lane
	input  logic [LANE_N-1:0]        ctrl_v_i,
	input  logic [LANE_N-1:0]        idle_v_i,
	input  logic [LANE_N-1:0]        start_v_i,
	input  logic [LANE_N-1:0]        term_v_i,
	input  logic [LANE_N-1:0]        err_v_i,
	input  logic [LANE_N*DATA_W-1:0] data_i,
	input  logic [LANE_N*KEEP_W-1:0] keep_i,
	output logic                     ready_o,    // inputs taken at the next edge
	output logic                     marker_v_o, // gearboxes take markers this cycle
	// SerDes side
	output logic [LANE_N*DATA_W-1:0] serdes_data_o
);

	logic [LANE_N*HEAD_W-1:0] blk_head; // registered blocks, per lane
	logic [LANE_N*DATA_W-1:0] blk_data;
	logic [LANE_N*DATA_W-1:0] am_data;  // marker payloads
	logic                     accept;   // lane 0 gearbox accept

	// MAC word only taken when the gearboxes want a data block
	assign ready_o = accept & ~marker_v_o;

	am_gen #(
		.AM_PERIOD(AM_PERIOD)
	) am_gen_inst (
		.clk       (clk),
		.rst_i     (rst_i),
		.accept_i  (accept),
		.marker_v_o(marker_v_o),
		.am_data_o (am_data)
	);

	for (genvar l = 0; l < LANE_N; l++) begin : g_lane
		pcs_scrambler #(
			.SEED_ALL_ONES(1'b1)
		) pcs_scrambler_inst (
			.clk       (clk),
			.rst_i     (rst_i),
			.advance_i (ready_o), // stalls together with the MAC
			.ctrl_v_i  (ctrl_v_i[l]),
			.idle_v_i  (idle_v_i[l]),
			.start_v_i (start_v_i[l]),
			.term_v_i  (term_v_i[l]),
			.err_v_i   (err_v_i[l]),
			.data_i    (data_i[l*DATA_W +: DATA_W]),
			.keep_i    (keep_i[l*KEEP_W +: KEEP_W]),
			.blk_head_o(blk_head[l*HEAD_W +: HEAD_W]),
			.blk_data_o(blk_data[l*DATA_W +: DATA_W])
		);

		// every gearbox runs the same fill sequence, lane 0 speaks for all
		if (l == 0) begin : g_lead
			gearbox_tx gearbox_tx_inst (
				.clk       (clk),
				.rst_i     (rst_i),
				.marker_v_i(marker_v_o),
				.am_data_i (am_data[l*DATA_W +: DATA_W]),
				.blk_head_i(blk_head[l*HEAD_W +: HEAD_W]),
				.blk_data_i(blk_data[l*DATA_W +: DATA_W]),
				.accept_o  (accept),
				.data_o    (serdes_data_o[l*DATA_W +: DATA_W])
			);
		end else begin : g_follow
			gearbox_tx gearbox_tx_inst (
				.clk       (clk),
				.rst_i     (rst_i),
				.marker_v_i(marker_v_o),
				.am_data_i (am_data[l*DATA_W +: DATA_W]),
				.blk_head_i(blk_head[l*HEAD_W +: HEAD_W]),
				.blk_data_i(blk_data[l*DATA_W +: DATA_W]),
				.accept_o  (),
				.data_o    (serdes_data_o[l*DATA_W +: DATA_W])
			);
		end
	end

endmodule

// ==== gearbox_tx.sv ====
// one lane 66-to-64 gearbox, packs marker or data blocks into a continuous SerDes word stream
module gearbox_tx import pcs_pkg::*; (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              marker_v_i, // send the marker instead of the data block
	input  logic [DATA_W-1:0] am_data_i,
	input  logic [HEAD_W-1:0] blk_head_i,
	input  logic [DATA_W-1:0] blk_data_i,
	output logic              accept_o,   // a block is consumed at this edge
	output logic [DATA_W-1:0] data_o      // SerDes word, bit 0 first
);

	localparam int BUF_W  = 2 * DATA_W;
	localparam int FILL_W = $clog2(BUF_W); // fill runs 0..64

	logic [BUF_W-1:0]   sh_q;   // pending bits, oldest at bit 0
	logic [FILL_W-1:0]  fill_q; // valid bits in sh_q
	logic [BLOCK_W-1:0] blk;
	logic [BUF_W-1:0]   merged;

	// block gains 2 bits each accept, full word left after 32 of them
	// so the pattern is 32 accepts then one skip
	assign accept_o = (fill_q < FILL_W'(DATA_W));

	always_comb begin
		if (marker_v_i) begin
			blk = {am_data_i, SYNC_CTRL}; // markers are control blocks, unscrambled
		end else begin
			blk = {blk_data_i, blk_head_i}; // header lands first
		end
	end

	// append new block behind the pending bits
	always_comb begin
		merged = sh_q;
		if (accept_o) begin
			merged = sh_q | ({{(BUF_W - BLOCK_W){1'b0}}, blk} << fill_q);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			sh_q   <= '0;
			fill_q <= '0;
			data_o <= '0;
		end else begin
			data_o <= merged[DATA_W-1:0]; // oldest 64 bits out every cycle
			sh_q   <= {{DATA_W{1'b0}}, merged[BUF_W-1:DATA_W]};
			if (accept_o) begin
				fill_q <= fill_q + FILL_W'(BLOCK_W - DATA_W);
			end else begin
				fill_q <= fill_q - FILL_W'(DATA_W); // drain the spare word
			end
		end
	end

endmodule

// ==== am_gen.sv ====
// alignment marker generator, counts accepted data cycles and flags the marker slot
module am_gen import pcs_pkg::*; #(
	parameter int AM_PERIOD = 64 // data cycles between markers, at least 2
)(
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic                     accept_i,   // gearboxes consume a block this edge
	output logic                     marker_v_o, // marker block is the one consumed next
	output logic [LANE_N*DATA_W-1:0] am_data_o   // per lane marker payloads
);

	localparam int CNT_W = $clog2(AM_PERIOD);

	logic [CNT_W-1:0] cnt_q; // data blocks since last marker

	always_ff @(posedge clk) begin
		if (rst_i) begin
			cnt_q      <= '0;
			marker_v_o <= 1'b0;
		end else if (accept_i) begin
			if (marker_v_o) begin
				marker_v_o <= 1'b0; // marker went out on this edge
			end else if (cnt_q == CNT_W'(AM_PERIOD - 1)) begin
				cnt_q      <= '0;
				marker_v_o <= 1'b1; // period done, marker next
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// marker layout, byte 0 first
	// M0 M1 M2 BIP3 M4 M5 M6 BIP7
	// BIP fields left at zero
	for (genvar l = 0; l < LANE_N; l++) begin : g_lane
		assign am_data_o[l*DATA_W +: DATA_W] = {
			8'h00,        // BIP7
			~AM_LANE[l],  // M6 M5 M4
			8'h00,        // BIP3
			AM_LANE[l]    // M2 M1 M0
		};
	end

endmodule

// ==== pcs_scrambler.sv ====
// one lane block path, encodes and scrambles the MAC word into a registered 66-bit block
module pcs_scrambler import pcs_pkg::*; #(
	parameter bit SEED_ALL_ONES = 1'b1 // reset value of every state bit
)(
	input  logic              clk,
	input  logic              rst_i,
	input  logic              advance_i, // take a new MAC word
	input  logic              ctrl_v_i,
	input  logic              idle_v_i,
	input  logic              start_v_i,
	input  logic              term_v_i,
	input  logic              err_v_i,
	input  logic [DATA_W-1:0] data_i,
	input  logic [KEEP_W-1:0] keep_i,
	output logic [HEAD_W-1:0] blk_head_o,
	output logic [DATA_W-1:0] blk_data_o
);

	localparam int SCR_W = 58; // x^58 + x^39 + 1

	logic [HEAD_W-1:0] enc_head;
	logic [DATA_W-1:0] enc_data;
	logic [SCR_W-1:0]  state_q;
	logic [SCR_W-1:0]  state_d;
	logic [DATA_W-1:0] scram;

	pcs_enc pcs_enc_inst (
		.ctrl_v_i   (ctrl_v_i),
		.idle_v_i   (idle_v_i),
		.start_v_i  (start_v_i),
		.term_v_i   (term_v_i),
		.err_v_i    (err_v_i),
		.data_i     (data_i),
		.keep_i     (keep_i),
		.sync_head_o(enc_head),
		.data_o     (enc_data)
	);

	// serial scrambler unrolled, bit 0 first
	always_comb begin
		state_d = state_q;
		for (int i = 0; i < DATA_W; i++) begin
			scram[i] = enc_data[i] ^ state_d[38] ^ state_d[SCR_W-1];
			state_d  = {state_d[SCR_W-2:0], scram[i]}; // feed back scrambled bit
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q    <= {SCR_W{SEED_ALL_ONES}};
			blk_head_o <= SYNC_CTRL;
			blk_data_o <= {{8{CTRL_IDLE}}, BT_IDLE}; // idle block until first word
		end else if (advance_i) begin
			state_q    <= state_d;
			blk_head_o <= enc_head; // header bypasses the scrambler
			blk_data_o <= scram;
		end
	end

endmodule

// ==== pcs_enc.sv ====
// 64b/66b block encoder for one lane, MAC strobes and data to sync header and payload
module pcs_enc import pcs_pkg::*; (
	input  logic              ctrl_v_i,  // control block
	input  logic              idle_v_i,
	input  logic              start_v_i,
	input  logic              term_v_i,
	input  logic              err_v_i,
	input  logic [DATA_W-1:0] data_i,
	input  logic [KEEP_W-1:0] keep_i,    // valid bytes ahead of terminate
	output logic [HEAD_W-1:0] sync_head_o,
	output logic [DATA_W-1:0] data_o
);

	enc_payload_u      pay;
	logic [3:0]        keep_cnt;  // 0..8
	logic [DATA_W-9:0] term_pay;  // data bytes then zeroed idle chars
	logic [7:0]        term_type;
	logic              term_ok;   // keep count maps to a terminate type
	logic              bad;       // fall back to error block

	// count enabled bytes
	always_comb begin
		keep_cnt = '0;
		for (int i = 0; i < KEEP_W; i++) begin
			keep_cnt = keep_cnt + {3'b000, keep_i[i]};
		end
	end

	// terminate payload, bytes past the count carry idle (all zero) bits
	always_comb begin
		for (int b = 0; b < KEEP_W - 1; b++) begin
			term_pay[8*b +: 8] = (4'(b) < keep_cnt) ? data_i[8*b +: 8] : 8'h00;
		end
	end

	// terminate type from byte count
	always_comb begin
		term_ok = 1'b1;
		case (keep_cnt)
			4'd0: term_type = BT_TERM0;
			4'd1: term_type = BT_TERM1;
			4'd2: term_type = BT_TERM2;
			4'd3: term_type = BT_TERM3;
			4'd4: term_type = BT_TERM4;
			4'd5: term_type = BT_TERM5;
			4'd6: term_type = BT_TERM6;
			4'd7: term_type = BT_TERM7;
			default: begin
				term_type = BT_ERR; // eight bytes never end in a terminate block
				term_ok   = 1'b0;
			end
		endcase
	end

	always_comb begin
		sync_head_o = SYNC_CTRL;
		pay.raw     = '0;
		bad         = 1'b0;
		if (!ctrl_v_i) begin
			sync_head_o = SYNC_DATA; // plain data, passed as is
			pay.raw     = data_i;
		end else if (err_v_i) begin
			bad = 1'b1; // error wins over any other strobe
		end else begin
			// exactly one block kind may be flagged
			case ({idle_v_i, start_v_i, term_v_i})
				3'b100: begin
					pay.ctrl.btype   = BT_IDLE;
					pay.ctrl.payload = {8{CTRL_IDLE}};
				end
				3'b010: begin
					pay.ctrl.btype   = BT_START;
					pay.ctrl.payload = data_i[DATA_W-1:8]; // byte 0 replaced by type
				end
				3'b001: begin
					pay.ctrl.btype   = term_type;
					pay.ctrl.payload = term_pay;
					bad              = ~term_ok;
				end
				default: bad = 1'b1; // unknown mix of strobes
			endcase
		end
		if (bad) begin
			pay.ctrl.btype   = BT_ERR;
			pay.ctrl.payload = {8{CTRL_ERR}};
		end
	end

	assign data_o = pay.raw;

endmodule

// ==== pcs_pkg.sv ====
// 40GBASE-R transmit PCS shared widths, block codes, sync headers and marker patterns
package pcs_pkg;

	localparam int LANE_N  = 4;  // pcs lanes
	localparam int DATA_W  = 64; // block payload
	localparam int HEAD_W  = 2;  // sync header
	localparam int BLOCK_W = DATA_W + HEAD_W;
	localparam int KEEP_W  = DATA_W / 8; // one enable per byte

	// bit 0 goes on the wire first, so data "01" reads as 2'b10
	localparam logic [HEAD_W-1:0] SYNC_DATA = 2'b10;
	localparam logic [HEAD_W-1:0] SYNC_CTRL = 2'b01;

	// block type field, first byte of a control block
	localparam logic [7:0] BT_IDLE  = 8'h1e; // all control characters
	localparam logic [7:0] BT_START = 8'h78; // start, data in bytes 1..7
	localparam logic [7:0] BT_TERM0 = 8'h87;
	localparam logic [7:0] BT_TERM1 = 8'h99;
	localparam logic [7:0] BT_TERM2 = 8'haa;
	localparam logic [7:0] BT_TERM3 = 8'hb4;
	localparam logic [7:0] BT_TERM4 = 8'hcc;
	localparam logic [7:0] BT_TERM5 = 8'hd2;
	localparam logic [7:0] BT_TERM6 = 8'he1;
	localparam logic [7:0] BT_TERM7 = 8'hff;
	localparam logic [7:0] BT_ERR   = 8'h1e; // same type as idle, error characters inside

	// 7 bit control characters
	localparam logic [6:0] CTRL_IDLE = 7'h00;
	localparam logic [6:0] CTRL_ERR  = 7'h1e;

	// per lane marker bytes packed as {M2, M1, M0}, M0 sent first
	// M4..M6 are the bitwise inverse of M0..M2
	localparam logic [LANE_N-1:0][23:0] AM_LANE = {
		24'h3d79a2, // lane 3
		24'h9b65c5, // lane 2
		24'he6c4f0, // lane 1
		24'h477690  // lane 0
	};

	// encoded block payload, bit 0 first on the wire
	// control blocks put their type byte in the low byte
	typedef union packed {
		logic [DATA_W-1:0] raw; // data block, or the word as sent
		struct packed {
			logic [DATA_W-9:0] payload; // control characters and data bytes
			logic [7:0]        btype;   // block type field
		} ctrl;
	} enc_payload_u;

endpackage
